//--- riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int WORD_WIDTH = 32;		// Data and address word
	localparam int ADDR_WIDTH = 5;		// Register index

	// Major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,		// R-type ALU
		OPC_OP_IMM = 7'b0010011,		// I-type ALU
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_STORE  = 7'b0100011
	} opcode_e;

	// funct3 of the ALU group
	localparam logic [2:0] F3_ADD_SUB = 3'b000;	// SUB only in OP with funct7[5]
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;	// funct7[5] picks SRA
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 of the branches
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// Stores and JALR
	localparam logic [2:0] F3_SB   = 3'b000;
	localparam logic [2:0] F3_SH   = 3'b001;
	localparam logic [2:0] F3_SW   = 3'b010;
	localparam logic [2:0] F3_JALR = 3'b000;	// Only legal encoding

endpackage

`default_nettype wire

//--- ex_ctrl_pkg.sv
`default_nettype none

package ex_ctrl_pkg;

	//////////////////////////////////////////////////////////////////////
	// ALU control
	//////////////////////////////////////////////////////////////////////

	localparam int ALU_OP_WIDTH = 4;

	// The ten RV32I integer operations
	typedef enum logic [ALU_OP_WIDTH-1:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,		// Also BEQ/BNE compare
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,		// Also BLT/BGE compare
		ALU_SLTU = 4'd4,		// Also BLTU/BGEU compare
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_e;

	//////////////////////////////////////////////////////////////////////
	// Write-back source
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		WB_ALU       = 2'd0,		// ALU result
		WB_UPPER_IMM = 2'd1,		// LUI bypass
		WB_PC_PLUS4  = 2'd2		// Link address of JAL/JALR
	} wb_sel_e;

endpackage

`default_nettype wire

//--- ex_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ex_ctrl_if;
	import riscv_isa_pkg::*;
	import ex_ctrl_pkg::*;

	logic                  valid;		// Legal instruction present
	logic                  illegal;		// Unknown encoding seen
	logic [WORD_WIDTH-1:0] instr;
	logic [WORD_WIDTH-1:0] pc;
	logic [WORD_WIDTH-1:0] rs1_data;
	logic [WORD_WIDTH-1:0] rs2_data;
	alu_op_e               alu_op;
	wb_sel_e               wb_sel;
	logic                  imm_sel;		// Operand B from immediate
	logic                  stype_sel;		// S immediate instead of I
	logic                  auipc_sel;		// PC as operand A, U immediate as B
	logic                  branch;
	logic                  branch_inv;	// Taken on nonzero result
	logic                  jal;
	logic                  jalr;
	logic                  wr_en;		// Instruction writes rd

	// Decode side
	modport producer (
		output valid, illegal, instr, pc, rs1_data, rs2_data, alu_op, wb_sel,
		output imm_sel, stype_sel, auipc_sel, branch, branch_inv, jal, jalr, wr_en
	);

	// Execute side
	modport consumer (
		input valid, illegal, instr, pc, rs1_data, rs2_data, alu_op, wb_sel,
		input imm_sel, stype_sel, auipc_sel, branch, branch_inv, jal, jalr, wr_en
	);

endinterface

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  wire logic                              clk_i,
	input  wire logic                              arst_n_i,
	input  wire logic                              valid_i,
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] instr_i,
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] pc_i,
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] rs1_data_i,
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] rs2_data_i,
	ex_ctrl_if.producer                            ctrl
);
	import riscv_isa_pkg::*;
	import ex_ctrl_pkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;
	alu_op_e    d_alu_op;
	wb_sel_e    d_wb_sel;
	logic       d_imm_sel, d_stype_sel, d_auipc_sel;
	logic       d_branch, d_branch_inv, d_jal, d_jalr, d_wr_en;
	logic       d_illegal;

	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	//////////////////////////////////////////////////////////////////////
	// Combinational decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		d_alu_op     = ALU_ADD;		// Address and AUIPC adds by default
		d_wb_sel     = WB_ALU;
		d_imm_sel    = 1'b0;
		d_stype_sel  = 1'b0;
		d_auipc_sel  = 1'b0;
		d_branch     = 1'b0;
		d_branch_inv = 1'b0;
		d_jal        = 1'b0;
		d_jalr       = 1'b0;
		d_wr_en      = 1'b0;
		d_illegal    = 1'b0;
		unique case (funct3)		// Shared funct3 map of OP and OP_IMM
			F3_ADD_SUB: d_alu_op = (instr_i[6:0] == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
			F3_SLL:     d_alu_op = ALU_SLL;
			F3_SLT:     d_alu_op = ALU_SLT;
			F3_SLTU:    d_alu_op = ALU_SLTU;
			F3_XOR:     d_alu_op = ALU_XOR;
			F3_SRL_SRA: d_alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
			F3_OR:      d_alu_op = ALU_OR;
			F3_AND:     d_alu_op = ALU_AND;
		endcase
		case (opcode_e'(instr_i[6:0]))
			OPC_OP: begin
				d_wr_en   = 1'b1;
				// funct7 is zero, or 0100000 for SUB and SRA only
				d_illegal = !((funct7 == 7'b0000000) || (funct7 == 7'b0100000 &&
					(funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)));
			end
			OPC_OP_IMM: begin
				d_wr_en   = 1'b1;
				d_imm_sel = 1'b1;
				if (funct3 == F3_ADD_SUB)
					d_alu_op = ALU_ADD;		// There is no SUBI
				if (funct3 == F3_SLL)
					d_illegal = (funct7 != 7'b0000000);
				else if (funct3 == F3_SRL_SRA)
					d_illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
			end
			OPC_LUI: begin
				d_wr_en  = 1'b1;
				d_wb_sel = WB_UPPER_IMM;	// ALU is bypassed
			end
			OPC_AUIPC: begin
				d_wr_en     = 1'b1;
				d_imm_sel   = 1'b1;
				d_auipc_sel = 1'b1;
				d_alu_op    = ALU_ADD;
			end
			OPC_JAL: begin
				d_wr_en  = 1'b1;
				d_jal    = 1'b1;
				d_wb_sel = WB_PC_PLUS4;
			end
			OPC_JALR: begin
				d_wr_en   = 1'b1;
				d_jalr    = 1'b1;
				d_wb_sel  = WB_PC_PLUS4;
				d_illegal = (funct3 != F3_JALR);
			end
			OPC_BRANCH: begin
				d_branch = 1'b1;		// Compare rs1 with rs2, zero test in EX
				unique case (funct3)
					F3_BEQ:  d_alu_op = ALU_SUB;
					F3_BNE:  begin d_alu_op = ALU_SUB;  d_branch_inv = 1'b1; end
					F3_BLT:  begin d_alu_op = ALU_SLT;  d_branch_inv = 1'b1; end
					F3_BGE:  d_alu_op = ALU_SLT;
					F3_BLTU: begin d_alu_op = ALU_SLTU; d_branch_inv = 1'b1; end
					F3_BGEU: d_alu_op = ALU_SLTU;
					default: d_illegal = 1'b1;		// 010 and 011 are reserved
				endcase
			end
			OPC_STORE: begin
				d_imm_sel   = 1'b1;		// Address only, no write
				d_stype_sel = 1'b1;
				d_alu_op    = ALU_ADD;
				d_illegal   = !(funct3 == F3_SB || funct3 == F3_SH || funct3 == F3_SW);
			end
			default: d_illegal = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Pipeline register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl.valid      <= 1'b0;
			ctrl.illegal    <= 1'b0;
			ctrl.alu_op     <= ALU_ADD;
			ctrl.wb_sel     <= WB_ALU;
			ctrl.imm_sel    <= 1'b0;
			ctrl.stype_sel  <= 1'b0;
			ctrl.auipc_sel  <= 1'b0;
			ctrl.branch     <= 1'b0;
			ctrl.branch_inv <= 1'b0;
			ctrl.jal        <= 1'b0;
			ctrl.jalr       <= 1'b0;
			ctrl.wr_en      <= 1'b0;
		end else begin
			ctrl.valid      <= valid_i && !d_illegal;	// Illegal words never execute
			ctrl.illegal    <= valid_i && d_illegal;
			ctrl.alu_op     <= d_alu_op;
			ctrl.wb_sel     <= d_wb_sel;
			ctrl.imm_sel    <= d_imm_sel;
			ctrl.stype_sel  <= d_stype_sel;
			ctrl.auipc_sel  <= d_auipc_sel;
			ctrl.branch     <= d_branch;
			ctrl.branch_inv <= d_branch_inv;
			ctrl.jal        <= d_jal;
			ctrl.jalr       <= d_jalr;
			ctrl.wr_en      <= d_wr_en;
		end
	end

	// Operands ride along with the control
	always_ff @(posedge clk_i) begin
		ctrl.instr    <= instr_i;
		ctrl.pc       <= pc_i;
		ctrl.rs1_data <= rs1_data_i;
		ctrl.rs2_data <= rs2_data_i;
	end

	// A flagged word must not reach execute as valid
	a_illegal_not_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ctrl.illegal |-> !ctrl.valid);

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] operand_a_i,
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] operand_b_i,
	input  wire ex_ctrl_pkg::alu_op_e                 operator_i,
	output logic      [riscv_isa_pkg::WORD_WIDTH-1:0] result_o
);
	import riscv_isa_pkg::*;
	import ex_ctrl_pkg::*;

	logic [4:0] shamt;		// Only the low five bits shift
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = operand_b_i[4:0];
	assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
	assign lt_unsigned = operand_a_i < operand_b_i;

	always_comb begin
		case (operator_i)
			ALU_ADD:  result_o = operand_a_i + operand_b_i;
			ALU_SUB:  result_o = operand_a_i - operand_b_i;	// Zero on equal operands
			ALU_SLL:  result_o = operand_a_i << shamt;
			ALU_SLT:  result_o = {{(WORD_WIDTH-1){1'b0}}, lt_signed};
			ALU_SLTU: result_o = {{(WORD_WIDTH-1){1'b0}}, lt_unsigned};
			ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
			ALU_SRL:  result_o = operand_a_i >> shamt;
			ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);	// Sign fill
			ALU_OR:   result_o = operand_a_i | operand_b_i;
			ALU_AND:  result_o = operand_a_i & operand_b_i;
			default:  result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
	input  wire logic                                 clk_i,
	input  wire logic                                 arst_n_i,
	ex_ctrl_if.consumer                               ctrl,
	output logic                                      valid_o,
	output logic                                      illegal_o,
	output logic                                      wb_en_o,
	output logic      [riscv_isa_pkg::ADDR_WIDTH-1:0] rd_addr_o,
	output logic      [riscv_isa_pkg::WORD_WIDTH-1:0] wb_data_o,
	output logic                                      branch_taken_o,
	output logic      [riscv_isa_pkg::WORD_WIDTH-1:0] branch_target_o
);
	import riscv_isa_pkg::*;
	import ex_ctrl_pkg::*;

	logic [WORD_WIDTH-1:0] i_imm, s_imm, b_imm, j_imm, u_imm;
	logic [WORD_WIDTH-1:0] lower_imm;		// I or S, for ALU and stores
	logic [WORD_WIDTH-1:0] alu_imm;
	logic [WORD_WIDTH-1:0] operand_a, operand_b;
	logic [WORD_WIDTH-1:0] alu_result;
	logic [WORD_WIDTH-1:0] pc_plus4;
	logic [WORD_WIDTH-1:0] wb_data;
	logic [WORD_WIDTH-1:0] target;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic                  zero_flag, cond_hit, taken, wb_en;

	//////////////////////////////////////////////////////////////////////
	// Immediates, all sign extended except U
	//////////////////////////////////////////////////////////////////////

	assign i_imm = {{20{ctrl.instr[31]}}, ctrl.instr[31:20]};
	assign s_imm = {{20{ctrl.instr[31]}}, ctrl.instr[31:25], ctrl.instr[11:7]};
	assign b_imm = {{19{ctrl.instr[31]}}, ctrl.instr[31], ctrl.instr[7],
		ctrl.instr[30:25], ctrl.instr[11:8], 1'b0};
	assign j_imm = {{11{ctrl.instr[31]}}, ctrl.instr[31], ctrl.instr[19:12],
		ctrl.instr[20], ctrl.instr[30:21], 1'b0};
	assign u_imm = {ctrl.instr[31:12], 12'b0};

	assign lower_imm = ctrl.stype_sel ? s_imm : i_imm;
	assign alu_imm   = ctrl.auipc_sel ? u_imm : lower_imm;

	// Operand muxes
	assign operand_a = ctrl.auipc_sel ? ctrl.pc : ctrl.rs1_data;		// PC only for AUIPC
	assign operand_b = ctrl.imm_sel ? alu_imm : ctrl.rs2_data;

	alu i_alu (
		.operand_a_i (operand_a),
		.operand_b_i (operand_b),
		.operator_i  (ctrl.alu_op),
		.result_o    (alu_result)
	);

	//////////////////////////////////////////////////////////////////////
	// Branch resolution and write-back
	//////////////////////////////////////////////////////////////////////

	assign zero_flag = (alu_result == '0);
	assign cond_hit  = ctrl.branch_inv ? !zero_flag : zero_flag;
	assign taken     = (ctrl.branch && cond_hit) || ctrl.jal || ctrl.jalr;

	assign pc_plus4 = ctrl.pc + WORD_WIDTH'(4);

	// JALR drops bit 0 of the sum
	assign target = ctrl.jalr ? ((ctrl.rs1_data + i_imm) & ~WORD_WIDTH'(1))
		: (ctrl.pc + (ctrl.jal ? j_imm : b_imm));

	always_comb begin
		case (ctrl.wb_sel)
			WB_UPPER_IMM: wb_data = u_imm;		// LUI
			WB_PC_PLUS4:  wb_data = pc_plus4;		// Link address
			default:      wb_data = alu_result;
		endcase
	end

	assign rd_addr = ctrl.instr[11:7];
	assign wb_en   = ctrl.valid && ctrl.wr_en && (rd_addr != '0);	// x0 is never written

	// Output register, data zeroed on idle cycles
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o         <= 1'b0;
			illegal_o       <= 1'b0;
			wb_en_o         <= 1'b0;
			branch_taken_o  <= 1'b0;
			rd_addr_o       <= '0;
			wb_data_o       <= '0;
			branch_target_o <= '0;
		end else begin
			valid_o         <= ctrl.valid;
			illegal_o       <= ctrl.illegal;		// Lines up with valid_o
			wb_en_o         <= wb_en;
			branch_taken_o  <= ctrl.valid && taken;
			rd_addr_o       <= ctrl.valid ? rd_addr : '0;
			wb_data_o       <= ctrl.valid ? wb_data : '0;
			branch_target_o <= ctrl.valid ? target : '0;
		end
	end

	a_taken_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		branch_taken_o |-> valid_o);

	// No write ever reaches x0
	a_wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		wb_en_o |-> (rd_addr_o != '0));

endmodule

`default_nettype wire

//--- ex_top.sv
`timescale 1ns/1ns
`default_nettype none

module ex_top (
	input  wire logic                                 clk_i,
	input  wire logic                                 arst_n_i,
	input  wire logic                                 valid_i,
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] instr_i,
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] pc_i,
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] rs1_data_i,
	input  wire logic [riscv_isa_pkg::WORD_WIDTH-1:0] rs2_data_i,
	output logic                                      valid_o,
	output logic                                      illegal_o,
	output logic                                      wb_en_o,
	output logic      [riscv_isa_pkg::ADDR_WIDTH-1:0] rd_addr_o,
	output logic      [riscv_isa_pkg::WORD_WIDTH-1:0] wb_data_o,
	output logic                                      branch_taken_o,
	output logic      [riscv_isa_pkg::WORD_WIDTH-1:0] branch_target_o
);

	ex_ctrl_if ctrl ();		// Decode to execute

	// Stage 1, registered decode
	decode_stage i_decode (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.valid_i    (valid_i),
		.instr_i    (instr_i),
		.pc_i       (pc_i),
		.rs1_data_i (rs1_data_i),
		.rs2_data_i (rs2_data_i),
		.ctrl       (ctrl.producer)
	);

	// Stage 2, ALU and result register
	ex_stage i_ex (
		.clk_i           (clk_i),
		.arst_n_i        (arst_n_i),
		.ctrl            (ctrl.consumer),
		.valid_o         (valid_o),
		.illegal_o       (illegal_o),
		.wb_en_o         (wb_en_o),
		.rd_addr_o       (rd_addr_o),
		.wb_data_o       (wb_data_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o)
	);

endmodule

`default_nettype wire

//--- tb_ex_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ex_top;
	import riscv_isa_pkg::*;

	localparam int NUM_INSTR = 2000;		// Random instructions per run
	localparam int WAIT_LIMIT = 50;		// Cycles allowed for any wait loop

	// Expected outputs of one cycle
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		logic                  wb_en;
		logic [ADDR_WIDTH-1:0] rd;
		logic [WORD_WIDTH-1:0] wb_data;
		logic                  taken;
		logic [WORD_WIDTH-1:0] target;
	} result_t;

	logic                  clk_i, arst_n_i, valid_i;
	logic [WORD_WIDTH-1:0] instr_i, pc_i, rs1_data_i, rs2_data_i;
	logic                  valid_o, illegal_o, wb_en_o, branch_taken_o;
	logic [ADDR_WIDTH-1:0] rd_addr_o;
	logic [WORD_WIDTH-1:0] wb_data_o, branch_target_o;

	logic [31:0] rng = 32'hc0d4;		// Xorshift state
	result_t     exp_d1 = '0;		// Two-deep delay line of expectations
	result_t     exp_d2 = '0;
	int          issued = 0;		// Valid inputs sent
	int          seen = 0;			// Valid or illegal outputs seen

	ex_top i_dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;		// 20 ns period
	end

	initial begin
		arst_n_i = 1'b0;
		repeat (16) @(posedge clk_i);
		arst_n_i <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] rand32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic check(input string field, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, field, got, expected);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// RV32I integer result by funct3 where alt selects SUB or SRA
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model built from the ISA rules
	//////////////////////////////////////////////////////////////////////

	function automatic result_t model(input logic vld, input logic [31:0] ins,
		input logic [31:0] pc, input logic [31:0] a, input logic [31:0] b);
		result_t     e;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] i_imm, s_imm, b_imm, j_imm, u_imm, res, tgt;
		logic        legal, wr, taken;
		f3 = ins[14:12];
		f7 = ins[31:25];
		i_imm = {{20{ins[31]}}, ins[31:20]};
		s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		u_imm = {ins[31:12], 12'b0};
		legal = 1'b1;
		wr    = 1'b0;
		taken = 1'b0;
		res   = '0;
		tgt   = pc + b_imm;		// Any non-jump points at the B target
		case (ins[6:0])
			7'h33: begin		// OP
				legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				wr    = 1'b1;
				res   = alu_model(f3, f7[5], a, b);
			end
			7'h13: begin		// OP_IMM where SRAI is the only alternate
				legal = (f3 == 3'd1) ? (f7 == 7'h00) :
					(f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
				wr    = 1'b1;
				res   = alu_model(f3, f3 == 3'd5 && f7[5], a, i_imm);
			end
			7'h37: begin
				wr  = 1'b1;
				res = u_imm;
			end
			7'h17: begin
				wr  = 1'b1;
				res = pc + u_imm;
			end
			7'h6f: begin
				wr    = 1'b1;
				res   = pc + 32'd4;
				taken = 1'b1;
				tgt   = pc + j_imm;
			end
			7'h67: begin
				legal = (f3 == 3'd0);
				wr    = 1'b1;
				res   = pc + 32'd4;
				taken = 1'b1;
				tgt   = (a + i_imm) & ~32'd1;		// Bit 0 cleared
			end
			7'h63: begin		// Compare result lands in wb_data
				case (f3)
					3'd0: begin
						res   = a - b;
						taken = (a == b);
					end
					3'd1: begin
						res   = a - b;
						taken = (a != b);
					end
					3'd4: begin
						res   = alu_model(3'd2, 1'b0, a, b);
						taken = $signed(a) < $signed(b);
					end
					3'd5: begin
						res   = alu_model(3'd2, 1'b0, a, b);
						taken = $signed(a) >= $signed(b);
					end
					3'd6: begin
						res   = alu_model(3'd3, 1'b0, a, b);
						taken = a < b;
					end
					3'd7: begin
						res   = alu_model(3'd3, 1'b0, a, b);
						taken = a >= b;
					end
					default: legal = 1'b0;
				endcase
			end
			7'h23: begin		// Address only
				legal = (f3 <= 3'd2);
				res   = a + s_imm;
			end
			default: legal = 1'b0;
		endcase
		e = '0;
		if (vld && !legal)
			e.illegal = 1'b1;		// Everything else stays zero
		else if (vld) begin
			e.valid   = 1'b1;
			e.rd      = ins[11:7];
			e.wb_en   = wr && (ins[11:7] != 5'd0);
			e.wb_data = res;
			e.taken   = taken;
			e.target  = tgt;
		end
		return e;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic drive_random(input logic force_valid);
		logic [31:0] r, ins, op1;
		logic [2:0]  f3;
		r   = rand32();
		ins = rand32();		// Random fields with the class bits fixed below
		op1 = rand32();
		f3  = ins[14:12];
		case (r % 9)
			0: begin
				ins[6:0]   = 7'h33;
				ins[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && r[8]) ? 7'h20 : 7'h00;
			end
			1: begin
				ins[6:0] = 7'h13;
				if (f3 == 3'd1)
					ins[31:25] = 7'h00;
				else if (f3 == 3'd5)
					ins[31:25] = r[8] ? 7'h20 : 7'h00;
			end
			2: ins[6:0] = 7'h37;
			3: ins[6:0] = 7'h17;
			4: ins[6:0] = 7'h6f;
			5: begin
				ins[6:0]   = 7'h67;
				ins[14:12] = 3'd0;
			end
			6: begin
				ins[6:0] = 7'h63;
				if (f3[2:1] == 2'b01)
					ins[14] = 1'b1;		// Skip the reserved codes
			end
			7: begin
				ins[6:0]   = 7'h23;
				ins[14:12] = 3'(f3 % 3'd3);
			end
			default: ins[6:0] = r[9] ? 7'h03 : 7'h7f;		// Unsupported opcode
		endcase
		valid_i    <= force_valid || (r[12:11] != 2'b00);
		instr_i    <= ins;
		pc_i       <= rand32() & ~32'd3;		// Word aligned
		rs1_data_i <= op1;
		rs2_data_i <= r[10] ? op1 : rand32();	// Equal operands now and then
	endtask

	initial begin
		int wait_cnt;
		valid_i    = 1'b0;
		instr_i    = '0;
		pc_i       = '0;
		rs1_data_i = '0;
		rs2_data_i = '0;
		wait_cnt   = 0;
		while (arst_n_i !== 1'b1) begin
			@(posedge clk_i);
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				report_timeout("reset release");
		end
		repeat (4) @(posedge clk_i);		// Idle outputs after reset
		for (int n = 0; n < NUM_INSTR; n++) begin
			@(posedge clk_i);
			drive_random(n >= NUM_INSTR / 2);		// Second half back to back
		end
		@(posedge clk_i);
		valid_i <= 1'b0;
		wait_cnt = 0;
		while (seen < issued) begin		// Drain the pipeline
			@(negedge clk_i);
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				report_timeout("the last results to drain");
		end
		$display("=== PASS ===");
		$finish;
	end

	// Compare at the falling edge against the expectation from two cycles back
	always @(negedge clk_i) begin : compare_outputs
		result_t fresh;
		fresh = arst_n_i ? model(valid_i, instr_i, pc_i, rs1_data_i, rs2_data_i) : '0;
		check("valid_o", 32'(valid_o), 32'(exp_d2.valid));
		check("illegal_o", 32'(illegal_o), 32'(exp_d2.illegal));
		check("wb_en_o", 32'(wb_en_o), 32'(exp_d2.wb_en));
		check("rd_addr_o", 32'(rd_addr_o), 32'(exp_d2.rd));
		check("wb_data_o", wb_data_o, exp_d2.wb_data);
		check("branch_taken_o", 32'(branch_taken_o), 32'(exp_d2.taken));
		check("branch_target_o", branch_target_o, exp_d2.target);
		if (valid_o || illegal_o)
			seen++;
		exp_d2 = exp_d1;
		exp_d1 = fresh;
		if (arst_n_i && valid_i)
			issued++;
	end

endmodule

`default_nettype wire

//--- tb.f
riscv_isa_pkg.sv
ex_ctrl_pkg.sv
ex_ctrl_if.sv
decode_stage.sv
alu.sv
ex_stage.sv
ex_top.sv
tb_ex_top.sv

//--- Makefile
TOP = tb_ex_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
